//--- Makefile
VERILATOR ?= verilator
TOP       ?= lcdFrameAdapterTb
FILELIST  ?= project.f
BUILD_DIR ?= build
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
RUN_FLAGS ?= +verilator+error+limit+100

SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	-$(SIM) $(RUN_FLAGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qF '*** TEST FAILED ***' $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@if ! grep -qF '*** TEST PASSED ***' $(LOG); then echo "Simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- dv/lcdFrameAdapterTb.sv
`timescale 1ns/1ps
`default_nettype none

module lcdFrameAdapterTb;

    localparam logic [15:0] WIDTH        = 16'd8;
    localparam logic [15:0] HEIGHT       = 16'd4;
    localparam int          PIXELS       = 32;
    localparam int          SLEEP_WAIT   = 10;
    localparam int          FRAME_WRITES = 17 + PIXELS;   // Window, 2C00h, pixels.
    localparam int          WAIT_LIMIT   = 2000;          // Cycles per wait.
    localparam logic [15:0] PIX_MASK     = 16'hA5C3;

    logic                clk;
    logic                rst_n;
    logic                memReady;
    logic                rdReq;
    memReadPkg::memAddrT rdAddr;
    logic                rdDone;
    memReadPkg::memWordT rdData0;
    memReadPkg::memWordT rdData1;
    memReadPkg::memWordT rdData2;
    memReadPkg::memWordT rdData3;
    logic                lcdRstN;
    logic                backlight;
    logic                csN;
    logic                rs;
    logic                wrN;
    logic                rdN;
    lcdPanelPkg::pixelT  lcdData;

    logic                expRs [$];             // Expected bus writes in order.
    lcdPanelPkg::pixelT  expData [$];
    int                  expWin [$];            // csN-low window of each write.
    string               expName [$];
    int                  errors = 0;
    int                  writeCount = 0;
    int                  csWindow = 0;
    int                  readCount = 0;
    int                  cycle = 0;
    int                  sleepOutAt = 0;
    int                  displayOnAt = 0;
    logic                prevWrN;
    logic                prevCsN;
    bit                  hung = 1'b0;
    logic [31:0]         rngState = 32'd44213;
    int                  delayLeft = 0;
    bit                  armed = 1'b0;
    memReadPkg::memAddrT expAddr = '0;

    lcdFrameAdapter #(
        .PANEL_WIDTH      (WIDTH),
        .PANEL_HEIGHT     (HEIGHT),
        .WR_LOW_CYCLES    (2),
        .RESET_CYCLES     (5),
        .SLEEP_OUT_CYCLES (SLEEP_WAIT)
    ) u_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .memReady  (memReady),
        .rdReq     (rdReq),
        .rdAddr    (rdAddr),
        .rdDone    (rdDone),
        .rdData0   (rdData0),
        .rdData1   (rdData1),
        .rdData2   (rdData2),
        .rdData3   (rdData3),
        .lcdRstN   (lcdRstN),
        .backlight (backlight),
        .csN       (csN),
        .rs        (rs),
        .wrN       (wrN),
        .rdN       (rdN),
        .lcdData   (lcdData)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;                 // 100 ns period.
    end

    always @(posedge clk) cycle <= cycle + 1;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic memReadPkg::memWordT storedWord(input memReadPkg::memAddrT a);
        return a[15:0] ^ PIX_MASK;              // Word k holds k XOR A5C3h.
    endfunction

    ////////////////////
    // Expected writes
    ////////////////////

    task automatic pushWrite(input logic r, input logic [15:0] d, input int win,
                             input string name);
        expRs.push_back(r);
        expData.push_back(d);
        expWin.push_back(win);
        expName.push_back(name);
    endtask

    task automatic pushPair(input logic [15:0] cmd, input logic [15:0] d, input int win,
                            input string name);
        pushWrite(1'b0, cmd, win, name);
        pushWrite(1'b1, d, win, name);
    endtask

    task automatic buildExpected();
        string       name;
        pushWrite(1'b0, 16'h1100, 1, "power-up");
        pushWrite(1'b0, 16'h2900, 1, "power-up");
        for (int frame = 1; frame <= 2; frame++) begin
            name = $sformatf("frame %0d window", frame);
            pushPair(16'h2A00, 16'h0000, frame + 1, name);
            pushPair(16'h2A01, 16'h0000, frame + 1, name);
            pushPair(16'h2A02, 16'h0000, frame + 1, name);
            pushPair(16'h2A03, 16'h0007, frame + 1, name);   // Last column of 8.
            pushPair(16'h2B00, 16'h0000, frame + 1, name);
            pushPair(16'h2B01, 16'h0000, frame + 1, name);
            pushPair(16'h2B02, 16'h0000, frame + 1, name);
            pushPair(16'h2B03, 16'h0003, frame + 1, name);   // Last row of 4.
            pushWrite(1'b0, 16'h2C00, frame + 1, name);
            name = $sformatf("frame %0d pixels", frame);
            for (int k = 0; k < PIXELS; k++) begin
                pushWrite(1'b1, 16'(k) ^ PIX_MASK, frame + 1, name);
            end
        end
    endtask

    ////////////////////
    // Frame memory model
    ////////////////////

    always @(negedge clk) begin
        if (!rst_n) begin
            rdDone <= 1'b0;
            armed = 1'b0;
        end else if (rdDone) begin
            rdDone <= 1'b0;                     // Done lasts one cycle.
        end else if (rdReq) begin
            if (!armed) begin
                rngState = xorshift(rngState);
                delayLeft = int'(rngState % 32'd6);   // 0 to 5 cycles.
                armed = 1'b1;
            end
            if (delayLeft == 0) begin
                assert (rdAddr == expAddr) else begin
                    errors++;
                    $display("[ERROR] read address: expected %0d, actual %0d", expAddr, rdAddr);
                end
                rdData0 <= storedWord(rdAddr);
                rdData1 <= storedWord(rdAddr + 24'd1);
                rdData2 <= storedWord(rdAddr + 24'd2);
                rdData3 <= storedWord(rdAddr + 24'd3);
                rdDone  <= 1'b1;
                expAddr = (expAddr == 24'(PIXELS - 4)) ? '0 : expAddr + 24'd4;
                readCount++;
                armed = 1'b0;
            end else begin
                delayLeft--;
            end
        end
    end

    ////////////////////
    // Panel bus monitor
    ////////////////////

    task automatic checkWrite(input int idx, input int win);
        assert (rdN === 1'b1) else begin
            errors++;
            $display("[ERROR] read strobe at write %0d: expected 1, actual %0b", idx, rdN);
        end
        if (idx >= expRs.size()) begin
            errors++;
            $display("Unexpected bus write number %0d after the expected sequence", idx);
        end else begin
            assert (rs == expRs[idx] && lcdData == expData[idx] && win == expWin[idx])
            else begin
                errors++;
                $display("[ERROR] %s write %0d: expected rs=%0b data=%h window=%0d, %s",
                         expName[idx], idx, expRs[idx], expData[idx], expWin[idx],
                         $sformatf("actual rs=%0b data=%h window=%0d", rs, lcdData, win));
            end
        end
    endtask

    always @(negedge clk) begin
        if (!rst_n) begin
            prevWrN <= 1'b1;
            prevCsN <= 1'b1;
        end else begin
            prevWrN <= wrN;
            prevCsN <= csN;
            if (prevCsN && !csN) csWindow <= csWindow + 1;    // New csN-low window.
            if (!prevWrN && wrN) begin                        // Panel latches here.
                checkWrite(writeCount, csWindow);
                if (writeCount == 0) sleepOutAt <= cycle;
                if (writeCount == 1) displayOnAt <= cycle;
                writeCount <= writeCount + 1;
            end
        end
    end

    ////////////////////
    // Waits
    ////////////////////

    task automatic reportTimeout(input string what);
        hung = 1'b1;
        errors++;
        $display("Timeout: %s did not happen within %0d cycles", what, WAIT_LIMIT);
    endtask

    task automatic waitResetLevel(input logic level);
        int cycles;
        cycles = 0;
        while (!hung && lcdRstN !== level) begin
            @(negedge clk);
            cycles++;
            if (cycles > WAIT_LIMIT) reportTimeout($sformatf("lcdRstN going to %0b", level));
        end
    endtask

    task automatic waitWriteCount(input int target, input string what);
        int cycles;
        cycles = 0;
        while (!hung && writeCount < target) begin
            @(negedge clk);
            cycles++;
            if (cycles > WAIT_LIMIT) reportTimeout(what);
        end
    endtask

    task automatic waitCsHigh(input string what);
        int cycles;
        cycles = 0;
        while (!hung && csN !== 1'b1) begin
            @(negedge clk);
            cycles++;
            if (cycles > WAIT_LIMIT) reportTimeout(what);
        end
    endtask

    task automatic checkGating();
        if (hung) return;
        for (int n = 0; n < 200; n++) begin
            @(negedge clk);
            assert (!rdReq) else begin
                errors++;
                $display("[ERROR] gating rdReq: expected 0, actual %0b", rdReq);
            end
        end
        assert (writeCount == 2) else begin
            errors++;
            $display("[ERROR] gating writes: expected 2, actual %0d", writeCount);
        end
    endtask

    task automatic runFrame(input int target, input string what);
        waitWriteCount(target, $sformatf("%s writes", what));
        waitCsHigh($sformatf("csN rising after %s", what));
        if (hung) return;
        assert (writeCount == target) else begin
            errors++;
            $display("[ERROR] %s write count: expected %0d, actual %0d", what, target, writeCount);
        end
    endtask

    ////////////////////
    // Main sequence
    ////////////////////

    initial begin
        rst_n    = 1'b0;
        memReady = 1'b0;
        rdDone   = 1'b0;
        rdData0  = '0;
        rdData1  = '0;
        rdData2  = '0;
        rdData3  = '0;
        buildExpected();
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        waitResetLevel(1'b0);                   // Panel reset pulse.
        waitResetLevel(1'b1);
        waitWriteCount(2, "power-up writes");
        waitCsHigh("csN rising after power-up");
        if (!hung) begin
            assert (displayOnAt - sleepOutAt >= SLEEP_WAIT) else begin
                errors++;
                $display("[ERROR] power-up sleep gap: expected at least %0d, actual %0d",
                         SLEEP_WAIT, displayOnAt - sleepOutAt);
            end
            assert (backlight) else begin
                errors++;
                $display("[ERROR] power-up backlight: expected 1, actual %0b", backlight);
            end
        end
        checkGating();                          // memReady still low.
        memReady = 1'b1;
        runFrame(2 + FRAME_WRITES, "frame 1");
        runFrame(2 + 2 * FRAME_WRITES, "frame 2");
        if (!hung) begin
            assert (readCount == 2 * PIXELS / 4) else begin
                errors++;
                $display("[ERROR] read count: expected %0d, actual %0d", 2 * PIXELS / 4, readCount);
            end
        end
        $display("Summary: %0d check errors, %0d assertion failures, %0d writes, %0d reads",
                 errors, u_dut.u_asserts.failCount, writeCount, readCount);
        if (errors == 0 && u_dut.u_asserts.failCount == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- dv/lcdFrameAdapter_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module lcdFrameAdapter_asserts #(
    parameter int          WR_LOW_CYCLES = 2,
    parameter logic [15:0] PANEL_WIDTH   = 16'd8,
    parameter logic [15:0] PANEL_HEIGHT  = 16'd4
) (
    input logic                clk,
    input logic                rst_n,
    input logic                csN,
    input logic                wrN,
    input logic                rdReq,
    input memReadPkg::memAddrT rdAddr,
    input logic                rdDone
);

    localparam int PIXELS = int'(PANEL_WIDTH) * int'(PANEL_HEIGHT);

    int failCount = 0;                          // Read by the testbench summary.
    int lowCnt;                                 // Sampled cycles with wrN low.

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lowCnt <= 0;
        end else if (wrN) begin
            lowCnt <= 0;
        end else begin
            lowCnt <= lowCnt + 1;
        end
    end

    ////////////////////
    // Panel bus
    ////////////////////

    wrNeedsCs: assert property (@(posedge clk) disable iff (!rst_n) !wrN |-> !csN)
        else begin
            $error("wrN is low while csN is high");
            failCount++;
        end

    strobeWidth: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(wrN) |-> (lowCnt == WR_LOW_CYCLES))
        else begin
            $error("wrN low pulse lasted %0d cycles", lowCnt);
            failCount++;
        end

    ////////////////////
    // Frame memory
    ////////////////////

    reqHeld: assert property (@(posedge clk) disable iff (!rst_n)
        (rdReq && !rdDone) |=> (rdReq && $stable(rdAddr)))
        else begin
            $error("rdReq or rdAddr changed before rdDone");
            failCount++;
        end

    reqDrops: assert property (@(posedge clk) disable iff (!rst_n)
        (rdReq && rdDone) |=> !rdReq)
        else begin
            $error("rdReq still high after rdDone");
            failCount++;
        end

    addrRange: assert property (@(posedge clk) disable iff (!rst_n)
        (rdAddr[1:0] == 2'b00) && (int'(rdAddr) < PIXELS))
        else begin
            $error("rdAddr %0d is unaligned or outside the frame", rdAddr);
            failCount++;
        end

endmodule

bind lcdFrameAdapter lcdFrameAdapter_asserts #(
    .WR_LOW_CYCLES (WR_LOW_CYCLES),
    .PANEL_WIDTH   (PANEL_WIDTH),
    .PANEL_HEIGHT  (PANEL_HEIGHT)
) u_asserts (
    .clk    (clk),
    .rst_n  (rst_n),
    .csN    (csN),
    .wrN    (wrN),
    .rdReq  (rdReq),
    .rdAddr (rdAddr),
    .rdDone (rdDone)
);

`default_nettype wire

//--- project.f
source/lcdPanelPkg.sv
source/memReadPkg.sv
source/lcdBusWriter.sv
source/frameFetcher.sv
source/lcdCommandSequencer.sv
source/lcdFrameAdapter.sv
dv/lcdFrameAdapter_asserts.sv
dv/lcdFrameAdapterTb.sv

//--- source/frameFetcher.sv
`timescale 1ns/1ps
`default_nettype none

module frameFetcher #(
    parameter logic [15:0] PANEL_WIDTH  = 16'd480,
    parameter logic [15:0] PANEL_HEIGHT = 16'd800
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                streamEn,
    output logic                rdReq,
    output memReadPkg::memAddrT rdAddr,
    input  logic                rdDone,
    input  memReadPkg::memWordT rdData0,
    input  memReadPkg::memWordT rdData1,
    input  memReadPkg::memWordT rdData2,
    input  memReadPkg::memWordT rdData3,
    output logic                pixValid,
    output lcdPanelPkg::pixelT  pixData,
    output logic                pixLast,
    input  logic                pixReady
);

    localparam int PIXELS = int'(PANEL_WIDTH) * int'(PANEL_HEIGHT);
    localparam memReadPkg::memAddrT LAST_ADDR =
        memReadPkg::memAddrT'(PIXELS - memReadPkg::BURST_WORDS);
    localparam memReadPkg::memAddrT ADDR_STEP = memReadPkg::memAddrT'(memReadPkg::BURST_WORDS);
    localparam int IDX_W = $clog2(memReadPkg::BURST_WORDS);
    localparam logic [IDX_W-1:0] IDX_LAST = IDX_W'(memReadPkg::BURST_WORDS - 1);

    memReadPkg::memWordT burstBuf [memReadPkg::BURST_WORDS];
    logic [IDX_W-1:0]    wordIdx;               // Next word to hand out.
    logic                bufFull;
    logic                lastBurst;             // Buffer holds the end of the frame.
    logic                pixTake;

    assign pixValid = bufFull;
    assign pixData  = burstBuf[wordIdx];
    assign pixLast  = bufFull && lastBurst && (wordIdx == IDX_LAST);
    assign pixTake  = bufFull && pixReady;

    ////////////////////
    // Read and drain
    ////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rdReq     <= 1'b0;
            rdAddr    <= '0;
            wordIdx   <= '0;
            bufFull   <= 1'b0;
            lastBurst <= 1'b0;
        end else begin
            if (rdReq) begin
                if (rdDone) begin
                    rdReq     <= 1'b0;              // Drop on the edge after done.
                    bufFull   <= 1'b1;
                    wordIdx   <= '0;
                    lastBurst <= (rdAddr == LAST_ADDR);
                    rdAddr    <= (rdAddr == LAST_ADDR) ? '0 : rdAddr + ADDR_STEP;
                end
            end else if (!bufFull && streamEn) begin
                rdReq <= 1'b1;                      // Only once the buffer is drained.
            end
            if (pixTake) begin
                wordIdx <= wordIdx + 1'b1;
                if (wordIdx == IDX_LAST) begin
                    bufFull <= 1'b0;                // Burst consumed.
                end
            end
        end
    end

    // Burst words are valid in the done cycle.
    always_ff @(posedge clk) begin
        if (rdReq && rdDone) begin
            burstBuf[0] <= rdData0;
            burstBuf[1] <= rdData1;
            burstBuf[2] <= rdData2;
            burstBuf[3] <= rdData3;
        end
    end

endmodule

`default_nettype wire

//--- source/lcdBusWriter.sv
`timescale 1ns/1ps
`default_nettype none

module lcdBusWriter #(
    parameter int WR_LOW_CYCLES = 2,
    parameter int RESET_CYCLES  = 1000
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               opValid,
    input  lcdPanelPkg::lcdOpE opCode,
    input  lcdPanelPkg::pixelT opData,
    output logic               opReady,
    output logic               lcdRstN,
    output logic               backlight,
    output logic               csN,
    output logic               rs,
    output logic               wrN,
    output logic               rdN,
    output lcdPanelPkg::pixelT lcdData
);

    localparam int LONGEST = (RESET_CYCLES > WR_LOW_CYCLES) ? RESET_CYCLES : WR_LOW_CYCLES;
    localparam int CNT_W   = $clog2(LONGEST) + 1;

    typedef enum logic [2:0] {
        bwIdle,                                 // Ready for the next op.
        bwReset,                                // lcdRstN held low.
        bwSetup,                                // rs and data settle.
        bwStrobe,                               // wrN low.
        bwHold                                  // Trailing cycle before ready.
    } busStateE;

    busStateE         state;
    logic [CNT_W-1:0] cnt;                      // Shared reset and strobe timer.
    logic             accept;
    logic             isWrite;

    assign opReady = (state == bwIdle);
    assign accept  = opValid && opReady;
    assign isWrite = (opCode == lcdPanelPkg::opWriteCmd) || (opCode == lcdPanelPkg::opWriteData);
    assign rdN     = 1'b1;                      // Panel is never read.

    ////////////////////
    // Bus FSM
    ////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= bwIdle;
            cnt       <= '0;
            lcdRstN   <= 1'b1;
            backlight <= 1'b0;
            csN       <= 1'b1;
            rs        <= 1'b1;
            wrN       <= 1'b1;
        end else begin
            case (state)
                bwIdle: begin
                    cnt <= '0;
                    if (accept) begin
                        case (opCode)
                            lcdPanelPkg::opReset: begin
                                lcdRstN <= 1'b0;        // Start of the reset pulse.
                                state   <= bwReset;
                            end
                            lcdPanelPkg::opChipSelect: begin
                                csN   <= opData[0];     // Level comes from bit 0.
                                state <= bwHold;
                            end
                            default: begin
                                rs    <= (opCode == lcdPanelPkg::opWriteData);
                                state <= bwSetup;
                            end
                        endcase
                    end
                end
                bwReset: begin
                    if (cnt == CNT_W'(RESET_CYCLES - 1)) begin
                        lcdRstN   <= 1'b1;
                        backlight <= 1'b1;              // Sticky from the first reset.
                        state     <= bwHold;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                bwSetup: begin
                    wrN   <= 1'b0;                      // Strobe opens.
                    state <= bwStrobe;
                end
                bwStrobe: begin
                    if (cnt == CNT_W'(WR_LOW_CYCLES - 1)) begin
                        wrN   <= 1'b1;                  // Panel latches on this edge.
                        state <= bwHold;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                bwHold:  state <= bwIdle;
                default: state <= bwIdle;
            endcase
        end
    end

    // Data stays put from setup until the next write.
    always_ff @(posedge clk) begin
        if (accept && isWrite) begin
            lcdData <= opData;
        end
    end

endmodule

`default_nettype wire

//--- source/lcdCommandSequencer.sv
`timescale 1ns/1ps
`default_nettype none

module lcdCommandSequencer #(
    parameter logic [15:0] PANEL_WIDTH      = 16'd480,
    parameter logic [15:0] PANEL_HEIGHT     = 16'd800,
    parameter int          SLEEP_OUT_CYCLES = 500
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               memReady,
    output logic               opValid,
    output lcdPanelPkg::lcdOpE opCode,
    output lcdPanelPkg::pixelT opData,
    input  logic               opReady,
    output logic               streamEn,
    input  logic               pixValid,
    input  lcdPanelPkg::pixelT pixData,
    input  logic               pixLast,
    output logic               pixReady
);

    // Step list: 0..4 power-up, 5..22 frame setup, 23 frame close.
    localparam logic [4:0] STEP_SLEEP_OUT   = 5'd2;
    localparam logic [4:0] STEP_POWER_DONE  = 5'd4;
    localparam logic [4:0] STEP_FRAME_START = 5'd5;
    localparam logic [4:0] STEP_MEM_WRITE   = 5'd22;
    localparam logic [4:0] STEP_FRAME_END   = 5'd23;
    localparam int         WAIT_W           = $clog2(SLEEP_OUT_CYCLES + 1);
    localparam lcdPanelPkg::pixelT X_END    = PANEL_WIDTH - 16'd1;
    localparam lcdPanelPkg::pixelT Y_END    = PANEL_HEIGHT - 16'd1;

    lcdPanelPkg::seqStateE state;
    logic [4:0]            step;
    logic [WAIT_W-1:0]     waitCnt;
    lcdPanelPkg::lcdOpE    stepCode;
    lcdPanelPkg::pixelT    stepData;
    logic                  inStream;
    logic                  opTake;

    ////////////////////
    // Step table
    ////////////////////

    always_comb begin
        stepCode = lcdPanelPkg::opWriteCmd;
        stepData = '0;
        case (step)
            5'd0:        stepCode = lcdPanelPkg::opReset;
            5'd1, 5'd5:  stepCode = lcdPanelPkg::opChipSelect;     // CS low.
            5'd2:        stepData = lcdPanelPkg::cmdSleepOut;
            5'd3:        stepData = lcdPanelPkg::cmdDisplayOn;
            5'd4, 5'd23: begin
                stepCode = lcdPanelPkg::opChipSelect;              // CS high.
                stepData = 16'd1;
            end
            5'd6:        stepData = lcdPanelPkg::cmdColAddr0;
            5'd8:        stepData = lcdPanelPkg::cmdColAddr1;
            5'd10:       stepData = lcdPanelPkg::cmdColAddr2;
            5'd12:       stepData = lcdPanelPkg::cmdColAddr3;
            5'd14:       stepData = lcdPanelPkg::cmdRowAddr0;
            5'd16:       stepData = lcdPanelPkg::cmdRowAddr1;
            5'd18:       stepData = lcdPanelPkg::cmdRowAddr2;
            5'd20:       stepData = lcdPanelPkg::cmdRowAddr3;
            5'd22:       stepData = lcdPanelPkg::cmdMemWrite;
            5'd7, 5'd9, 5'd15, 5'd17: stepCode = lcdPanelPkg::opWriteData;  // Start is 0,0.
            5'd11: begin
                stepCode = lcdPanelPkg::opWriteData;
                stepData = {8'h00, X_END[15:8]};
            end
            5'd13: begin
                stepCode = lcdPanelPkg::opWriteData;
                stepData = {8'h00, X_END[7:0]};
            end
            5'd19: begin
                stepCode = lcdPanelPkg::opWriteData;
                stepData = {8'h00, Y_END[15:8]};
            end
            5'd21: begin
                stepCode = lcdPanelPkg::opWriteData;
                stepData = {8'h00, Y_END[7:0]};
            end
            default: ;
        endcase
    end

    assign inStream = (state == lcdPanelPkg::stStream);
    assign opValid  = (state == lcdPanelPkg::stIssue) || (inStream && pixValid);
    assign opCode   = inStream ? lcdPanelPkg::opWriteData : stepCode;
    assign opData   = inStream ? pixData : stepData;
    assign opTake   = opValid && opReady;
    assign streamEn = inStream;
    assign pixReady = inStream && opReady;          // Pixel moves with the bus op.

    ////////////////////
    // Step machine
    ////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= lcdPanelPkg::stIdle;
            step    <= '0;
            waitCnt <= '0;
        end else begin
            case (state)
                lcdPanelPkg::stIdle: state <= lcdPanelPkg::stIssue;
                lcdPanelPkg::stIssue: begin
                    if (opTake) begin
                        case (step)
                            STEP_SLEEP_OUT:  state <= lcdPanelPkg::stSleepWait;
                            STEP_POWER_DONE: state <= lcdPanelPkg::stWaitMem;
                            STEP_MEM_WRITE:  state <= lcdPanelPkg::stStream;
                            STEP_FRAME_END:  state <= lcdPanelPkg::stWaitMem;
                            default: ;
                        endcase
                        step <= (step == STEP_FRAME_END) ? STEP_FRAME_START : step + 5'd1;
                    end
                end
                lcdPanelPkg::stSleepWait: begin
                    if (opReady) begin                      // Count from write completion.
                        if (waitCnt == WAIT_W'(SLEEP_OUT_CYCLES - 1)) begin
                            waitCnt <= '0;
                            state   <= lcdPanelPkg::stIssue;
                        end else begin
                            waitCnt <= waitCnt + 1'b1;
                        end
                    end
                end
                lcdPanelPkg::stWaitMem: begin
                    if (memReady) begin
                        state <= lcdPanelPkg::stIssue;
                    end
                end
                lcdPanelPkg::stStream: begin
                    if (opTake && pixLast) begin
                        state <= lcdPanelPkg::stIssue;      // Close the frame with CS high.
                    end
                end
                default: state <= lcdPanelPkg::stIdle;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- source/lcdFrameAdapter.sv
`timescale 1ns/1ps
`default_nettype none

module lcdFrameAdapter #(
    parameter logic [15:0] PANEL_WIDTH      = 16'd480,
    parameter logic [15:0] PANEL_HEIGHT     = 16'd800,
    parameter int          WR_LOW_CYCLES    = 2,
    parameter int          RESET_CYCLES     = 1000,
    parameter int          SLEEP_OUT_CYCLES = 500
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                memReady,
    output logic                rdReq,
    output memReadPkg::memAddrT rdAddr,
    input  logic                rdDone,
    input  memReadPkg::memWordT rdData0,
    input  memReadPkg::memWordT rdData1,
    input  memReadPkg::memWordT rdData2,
    input  memReadPkg::memWordT rdData3,
    output logic                lcdRstN,
    output logic                backlight,
    output logic                csN,
    output logic                rs,
    output logic                wrN,
    output logic                rdN,
    output lcdPanelPkg::pixelT  lcdData
);

    ////////////////////
    // Internal links
    ////////////////////

    logic               opValid;                // Sequencer to bus writer.
    lcdPanelPkg::lcdOpE opCode;
    lcdPanelPkg::pixelT opData;
    logic               opReady;
    logic               streamEn;               // Sequencer to fetcher.
    logic               pixValid;
    lcdPanelPkg::pixelT pixData;
    logic               pixLast;
    logic               pixReady;

    lcdBusWriter #(
        .WR_LOW_CYCLES (WR_LOW_CYCLES),
        .RESET_CYCLES  (RESET_CYCLES)
    ) u_busWriter (
        .clk       (clk),
        .rst_n     (rst_n),
        .opValid   (opValid),
        .opCode    (opCode),
        .opData    (opData),
        .opReady   (opReady),
        .lcdRstN   (lcdRstN),
        .backlight (backlight),
        .csN       (csN),
        .rs        (rs),
        .wrN       (wrN),
        .rdN       (rdN),
        .lcdData   (lcdData)
    );

    frameFetcher #(
        .PANEL_WIDTH  (PANEL_WIDTH),
        .PANEL_HEIGHT (PANEL_HEIGHT)
    ) u_fetcher (
        .clk      (clk),
        .rst_n    (rst_n),
        .streamEn (streamEn),
        .rdReq    (rdReq),
        .rdAddr   (rdAddr),
        .rdDone   (rdDone),
        .rdData0  (rdData0),
        .rdData1  (rdData1),
        .rdData2  (rdData2),
        .rdData3  (rdData3),
        .pixValid (pixValid),
        .pixData  (pixData),
        .pixLast  (pixLast),
        .pixReady (pixReady)
    );

    lcdCommandSequencer #(
        .PANEL_WIDTH      (PANEL_WIDTH),
        .PANEL_HEIGHT     (PANEL_HEIGHT),
        .SLEEP_OUT_CYCLES (SLEEP_OUT_CYCLES)
    ) u_sequencer (
        .clk      (clk),
        .rst_n    (rst_n),
        .memReady (memReady),
        .opValid  (opValid),
        .opCode   (opCode),
        .opData   (opData),
        .opReady  (opReady),
        .streamEn (streamEn),
        .pixValid (pixValid),
        .pixData  (pixData),
        .pixLast  (pixLast),
        .pixReady (pixReady)
    );

endmodule

`default_nettype wire

//--- source/lcdPanelPkg.sv
`default_nettype none

package lcdPanelPkg;

    ////////////////////
    // Bus words
    ////////////////////

    typedef logic [15:0] pixelT;                // RGB565 pixel or raw bus word.

    // Operations the bus writer can run.
    typedef enum logic [1:0] {
        opReset      = 2'd0,                    // Pulse the panel reset pin.
        opChipSelect = 2'd1,                    // Bit 0 of data sets csN.
        opWriteCmd   = 2'd2,                    // Strobe with rs low.
        opWriteData  = 2'd3                     // Strobe with rs high.
    } lcdOpE;

    ////////////////////
    // Panel commands
    ////////////////////

    typedef enum logic [15:0] {
        cmdSleepOut  = 16'h1100,                // Leave sleep mode.
        cmdDisplayOn = 16'h2900,                // Enable the output.
        cmdColAddr0  = 16'h2A00,                // Column start, high byte.
        cmdColAddr1  = 16'h2A01,                // Column start, low byte.
        cmdColAddr2  = 16'h2A02,                // Column end, high byte.
        cmdColAddr3  = 16'h2A03,                // Column end, low byte.
        cmdRowAddr0  = 16'h2B00,                // Row start, high byte.
        cmdRowAddr1  = 16'h2B01,                // Row start, low byte.
        cmdRowAddr2  = 16'h2B02,                // Row end, high byte.
        cmdRowAddr3  = 16'h2B03,                // Row end, low byte.
        cmdMemWrite  = 16'h2C00                 // Start of pixel data.
    } lcdCmdE;

    ////////////////////
    // Sequencer
    ////////////////////

    typedef enum logic [2:0] {
        stIdle,                                 // One quiet cycle out of reset.
        stIssue,                                // Run the op at the step index.
        stSleepWait,                            // Delay after sleep-out.
        stWaitMem,                              // Hold until frame memory is ready.
        stStream                                // Pixels straight to the bus.
    } seqStateE;

endpackage

`default_nettype wire

//--- source/memReadPkg.sv
`default_nettype none

package memReadPkg;

    ////////////////////
    // Frame memory
    ////////////////////

    typedef logic [23:0] memAddrT;              // Word address.
    typedef logic [15:0] memWordT;              // One stored word.

    localparam int BURST_WORDS = 4;             // Words returned per read.

endpackage

`default_nettype wire
